//--- build.f
+incdir+.
avl_tg_pkg.sv
avl_tg_fifo.sv
avl_tg_wdata_gen.sv
avl_tg_sequencer.sv
avl_tg_srw_if.sv
avl_tg_top.sv
avl_tg_chk.sv
avl_tg_tb.sv

//--- Makefile
# Verilator build and run for the Avalon traffic generator
# Override any variable on the command line, e.g. make OBJ_DIR=build

VERILATOR ?= verilator
TOP       ?= avl_tg_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from searching the simulation output for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- avl_tg_tb.sv
/*
  Testbench for avl_tg_top, random Avalon stalls on both ports
  Expected beats come from the loop rules and a model of the Galois LFSR
  Run length is bounded by a cycle limit scaled from the expected traffic
*/
`default_nettype none
`timescale 1ns/10ps

`include "avl_tg_macros.svh"

module avl_tg_tb;

   localparam int NUM_LOOPS    = `AVL_TG_NUM_LOOPS;
   localparam int RESET_CYCLES = 10;
   localparam int DRAIN_CYCLES = 20;
   localparam int MARGIN       = 40;

   logic                    clk = 1'b0;
   logic                    reset_n;
   logic                    start;
   logic                    avl_ready_w;
   logic                    avl_ready_r;
   logic                    avl_write_req;
   logic                    avl_read_req;
   logic                    done;
   avl_tg_pkg::avl_wr_cmd_t avl_wr;
   avl_tg_pkg::avl_rd_cmd_t avl_rd;

   // Expected traffic, in Avalon order per port
   avl_tg_pkg::avl_wr_cmd_t exp_wr[$];
   avl_tg_pkg::avl_rd_cmd_t exp_rd[$];

   integer seed          = 32'h3721_7fc2;
   int     err_count     = 0;
   int     wr_count      = 0;
   int     rd_count      = 0;
   int     wr_total      = 0;
   int     rd_total      = 0;
   int     cycle_cnt     = 0;
   int     timeout_limit = 0;
   bit     done_seen     = 1'b0;

   avl_tg_top i_dut (
      .clk           (clk),
      .reset_n       (reset_n),
      .start         (start),
      .avl_ready_w   (avl_ready_w),
      .avl_ready_r   (avl_ready_r),
      .avl_write_req (avl_write_req),
      .avl_wr        (avl_wr),
      .avl_read_req  (avl_read_req),
      .avl_rd        (avl_rd),
      .done          (done)
   );

   bind avl_tg_srw_if avl_tg_chk i_chk (
      .clk           (clk),
      .reset_n       (reset_n),
      .avl_write_req (avl_write_req),
      .avl_ready_w   (avl_ready_w),
      .avl_wr        (avl_wr),
      .avl_read_req  (avl_read_req),
      .avl_ready_r   (avl_ready_r),
      .avl_rd        (avl_rd),
      .ready_w       (ready_w),
      .wr_full       (wr_full),
      .wr_state      (wr_state)
   );

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Right shift, mask applied when a 1 falls out of bit 0
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic [31:0] nxt;
      nxt = state >> 1;
      if (state[0])
         nxt = nxt ^ `AVL_TG_LFSR_POLY;
      return nxt;
   endfunction

   // Per loop: random burst, inverted burst, one read of the region
   function automatic void build_expected();
      logic [31:0]             data_s;
      logic [31:0]             be_s;
      logic [`AVL_TG_BE_W-1:0] be_hist [8];
      avl_tg_pkg::avl_wr_cmd_t w;
      avl_tg_pkg::avl_rd_cmd_t r;
      int                      burst;
      data_s = `AVL_TG_DATA_SEED;
      be_s   = `AVL_TG_BE_SEED;
      for (int i = 0; i < NUM_LOOPS; i++)
      begin
         burst  = (i % 8) + 1;
         w.addr = `AVL_TG_ADDR_W'(i * `AVL_TG_ADDR_STRIDE);
         w.size = `AVL_TG_BURST_W'(burst);
         // Data and be move together, byte 0 always enabled
         for (int k = 0; k < burst; k++)
         begin
            be_hist[k] = {be_s[`AVL_TG_BE_W-1:1], 1'b1};
            w.wdata    = data_s[`AVL_TG_DATA_W-1:0];
            w.be       = be_hist[k];
            exp_wr.push_back(w);
            data_s = lfsr_step(data_s);
            be_s   = lfsr_step(be_s);
         end
         // Zeros under the complement of the matching beat
         for (int k = 0; k < burst; k++)
         begin
            w.wdata = '0;
            w.be    = ~be_hist[k];
            exp_wr.push_back(w);
         end
         r.addr = w.addr;
         r.size = w.size;
         exp_rd.push_back(r);
      end
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual)
      begin
         $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
         err_count++;
      end
   endtask

   function automatic bit run_complete();
      return done && (wr_count == wr_total) && (rd_count == rd_total);
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Clock, stalls and monitor
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      forever #5 clk = ~clk;
   end

   always @(posedge clk)
      cycle_cnt <= cycle_cnt + 1;

   // Roughly 70% ready on each port
   initial
   begin
      forever
      begin
         @(negedge clk);
         avl_ready_w = (($unsigned($random(seed)) % 10) < 7);
         avl_ready_r = (($unsigned($random(seed)) % 10) < 7);
      end
   end

   // Pre-edge values are the ones that transferred on this edge
   always @(posedge clk)
   begin
      avl_tg_pkg::avl_wr_cmd_t ew;
      avl_tg_pkg::avl_rd_cmd_t er;
      if (reset_n)
      begin
         // done only after every read left, then held
         // Count here still excludes a read on this same edge
         if (done && !done_seen)
         begin
            check_value("reads before done", 64'(rd_total), 64'(rd_count));
            done_seen = 1'b1;
         end
         else if (!done && done_seen)
         begin
            $display("done fell at cycle %0d after it was set", cycle_cnt);
            err_count++;
            done_seen = 1'b0;
         end
         if (avl_write_req && avl_ready_w)
         begin
            if (exp_wr.size() == 0)
            begin
               $display("Extra write beat at cycle %0d beyond the expected total", cycle_cnt);
               err_count++;
            end
            else
            begin
               ew = exp_wr.pop_front();
               check_value($sformatf("write beat %0d addr", wr_count),
                           64'(ew.addr), 64'(avl_wr.addr));
               check_value($sformatf("write beat %0d size", wr_count),
                           64'(ew.size), 64'(avl_wr.size));
               check_value($sformatf("write beat %0d wdata", wr_count),
                           64'(ew.wdata), 64'(avl_wr.wdata));
               check_value($sformatf("write beat %0d be", wr_count),
                           64'(ew.be), 64'(avl_wr.be));
            end
            wr_count++;
         end
         if (avl_read_req && avl_ready_r)
         begin
            if (exp_rd.size() == 0)
            begin
               $display("Extra read command at cycle %0d beyond the expected total", cycle_cnt);
               err_count++;
            end
            else
            begin
               er = exp_rd.pop_front();
               check_value($sformatf("read cmd %0d addr", rd_count),
                           64'(er.addr), 64'(avl_rd.addr));
               check_value($sformatf("read cmd %0d size", rd_count),
                           64'(er.size), 64'(avl_rd.size));
            end
            rd_count++;
         end
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////////////////////////
   initial
   begin
      reset_n     = 1'b0;
      start       = 1'b0;
      avl_ready_w = 1'b0;
      avl_ready_r = 1'b0;
      build_expected();
      wr_total      = exp_wr.size();
      rd_total      = exp_rd.size();
      timeout_limit = 4 * (wr_total + rd_total) + RESET_CYCLES + MARGIN;

      repeat (RESET_CYCLES) @(negedge clk);
      reset_n = 1'b1;
      repeat (2) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;

      // Counters are sampled between edges, after the monitor updated them
      while (!run_complete() && cycle_cnt < timeout_limit)
         @(negedge clk);

      if (!run_complete())
      begin
         $display("Timeout: run did not finish within %0d cycles", timeout_limit);
         err_count++;
      end
      else
      begin
         // Idle a while so duplicate beats would show up
         repeat (DRAIN_CYCLES) @(negedge clk);
         check_value("write beat total", 64'(wr_total), 64'(wr_count));
         check_value("read command total", 64'(rd_total), 64'(rd_count));
      end

      $display("Errors: %0d, write beats %0d of %0d, read commands %0d of %0d",
               err_count, wr_count, wr_total, rd_count, rd_total);
      if (err_count == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

//--- avl_tg_chk.sv
/*
  Avalon hold rules, reset state and write FSM idle rule
  Bound into avl_tg_srw_if, so port names match that module's signals
*/
`default_nettype none
`timescale 1ns/10ps

module avl_tg_chk (
   input logic                    clk,
   input logic                    reset_n,
   input logic                    avl_write_req,
   input logic                    avl_ready_w,
   input avl_tg_pkg::avl_wr_cmd_t avl_wr,
   input logic                    avl_read_req,
   input logic                    avl_ready_r,
   input avl_tg_pkg::avl_rd_cmd_t avl_rd,
   input logic                    ready_w,
   input logic                    wr_full,
   input avl_tg_pkg::wr_state_e   wr_state
);

   // Stalled write keeps its request and its bundle
   wr_hold: assert property (@(posedge clk) disable iff (!reset_n)
      (avl_write_req && !avl_ready_w) |=> (avl_write_req && $stable(avl_wr)))
      else $error("write bundle changed while the slave stalled");

   // Stalled read, same rule
   rd_hold: assert property (@(posedge clk) disable iff (!reset_n)
      (avl_read_req && !avl_ready_r) |=> (avl_read_req && $stable(avl_rd)))
      else $error("read bundle changed while the slave stalled");

   // Both requests drop in the cycle after a reset edge
   rst_idle: assert property (@(posedge clk)
      !reset_n |=> (!avl_write_req && !avl_read_req))
      else $error("Avalon request high after reset");

   // New write commands only taken between bursts
   wr_idle: assert property (@(posedge clk) disable iff (!reset_n)
      (ready_w && !wr_full) |-> (wr_state == avl_tg_pkg::WR_IDLE))
      else $error("ready_w high while a write burst is expanding");

endmodule

`default_nettype wire

//--- avl_tg_top.sv
/*
  Traffic generator top, one start pulse runs all loops
  Avalon ports follow the request/ready level rule
*/
`default_nettype none
`timescale 1ns/10ps

`include "avl_tg_macros.svh"

module avl_tg_top (
   input  logic                    clk,
   input  logic                    reset_n,
   input  logic                    start,
   input  logic                    avl_ready_w,
   input  logic                    avl_ready_r,
   output logic                    avl_write_req,
   output avl_tg_pkg::avl_wr_cmd_t avl_wr,
   output logic                    avl_read_req,
   output avl_tg_pkg::avl_rd_cmd_t avl_rd,
   output logic                    done
);

   // Sequencer and translator handshake
   avl_tg_pkg::tg_req_t       wr_cmd;
   avl_tg_pkg::tg_req_t       rd_cmd;
   logic                      ready_w;
   logic                      ready_r;
   logic                      write_done;

   // Data generator
   logic                      wdata_gen_enable;
   logic                      inv_be_gen_enable;
   logic [`AVL_TG_DATA_W-1:0] wdata;
   logic [`AVL_TG_BE_W-1:0]   be;
   logic [`AVL_TG_BE_W-1:0]   inv_be;

   avl_tg_sequencer i_sequencer (
      .clk        (clk),
      .reset_n    (reset_n),
      .start      (start),
      .ready_w    (ready_w),
      .ready_r    (ready_r),
      .wr_cmd     (wr_cmd),
      .rd_cmd     (rd_cmd),
      .write_done (write_done),
      .done       (done)
   );

   avl_tg_wdata_gen i_wdata_gen (
      .clk               (clk),
      .reset_n           (reset_n),
      .wdata_gen_enable  (wdata_gen_enable),
      .inv_be_gen_enable (inv_be_gen_enable),
      .wdata             (wdata),
      .be                (be),
      .inv_be            (inv_be)
   );

   avl_tg_srw_if i_srw_if (
      .clk               (clk),
      .reset_n           (reset_n),
      .wr_cmd            (wr_cmd),
      .rd_cmd            (rd_cmd),
      .wdata             (wdata),
      .be                (be),
      .inv_be            (inv_be),
      .avl_ready_w       (avl_ready_w),
      .avl_ready_r       (avl_ready_r),
      .ready_w           (ready_w),
      .ready_r           (ready_r),
      .wdata_gen_enable  (wdata_gen_enable),
      .inv_be_gen_enable (inv_be_gen_enable),
      .avl_write_req     (avl_write_req),
      .avl_wr            (avl_wr),
      .avl_read_req      (avl_read_req),
      .avl_rd            (avl_rd),
      .write_done        (write_done)
   );

endmodule

`default_nettype wire

//--- avl_tg_srw_if.sv
/*
  Sequencer commands to separate Avalon-MM write and read ports
  Write bursts become one FIFO entry per beat, read commands one entry each
  Avalon outputs are held while the slave stalls a pending request
*/
`default_nettype none
`timescale 1ns/10ps

`include "avl_tg_macros.svh"

module avl_tg_srw_if (
   input  logic                        clk,
   input  logic                        reset_n,
   input  avl_tg_pkg::tg_req_t         wr_cmd,
   input  avl_tg_pkg::tg_req_t         rd_cmd,
   input  logic [`AVL_TG_DATA_W-1:0]   wdata,
   input  logic [`AVL_TG_BE_W-1:0]     be,
   input  logic [`AVL_TG_BE_W-1:0]     inv_be,
   input  logic                        avl_ready_w,
   input  logic                        avl_ready_r,
   output logic                        ready_w,
   output logic                        ready_r,
   output logic                        wdata_gen_enable,
   output logic                        inv_be_gen_enable,
   output logic                        avl_write_req,
   output avl_tg_pkg::avl_wr_cmd_t     avl_wr,
   output logic                        avl_read_req,
   output avl_tg_pkg::avl_rd_cmd_t     avl_rd,
   output logic                        write_done
);

   // Write FIFO entry, one per beat
   typedef struct packed
   {
      logic                       inv;
      logic [`AVL_TG_ADDR_W-1:0]  addr;
      logic [`AVL_TG_BURST_W-1:0] size;
   } wr_entry_t;

   avl_tg_pkg::tg_req_t       wr_req_r;
   avl_tg_pkg::tg_req_t       rd_req_r;
   avl_tg_pkg::wr_state_e     wr_state;
   logic [`AVL_TG_BURST_W-1:0] beat_cnt;
   logic [`AVL_TG_ADDR_W-1:0]  last_addr;
   logic [`AVL_TG_BURST_W-1:0] last_size;
   logic                       wr_pending;
   logic                       rd_pending;

   logic                       wr_push;
   logic                       wr_pop;
   logic                       wr_full;
   logic                       wr_empty;
   wr_entry_t                  wr_din;
   wr_entry_t                  wr_dout;

   logic                       rd_push;
   logic                       rd_pop;
   logic                       rd_full;
   logic                       rd_empty;
   avl_tg_pkg::avl_rd_cmd_t    rd_din;
   avl_tg_pkg::avl_rd_cmd_t    rd_dout;

   // Port free when idle or the current request transfers
   logic                       can_issue_w;
   logic                       can_issue_r;

   assign can_issue_w = avl_ready_w | ~avl_write_req;
   assign can_issue_r = avl_ready_r | ~avl_read_req;
   assign wr_pending  = (wr_req_r.op == avl_tg_pkg::CMD_WRITE) ||
                        (wr_req_r.op == avl_tg_pkg::CMD_INV_WRITE);
   assign rd_pending  = (rd_req_r.op == avl_tg_pkg::CMD_READ);

   // Command registers, loaded whenever ready is high
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         wr_req_r <= '0;
         rd_req_r <= '0;
      end
      else
      begin
         if (ready_w)
            wr_req_r <= wr_cmd;
         if (ready_r)
            rd_req_r <= rd_cmd;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Write burst expansion
   //////////////////////////////////////////////////////////////////////

   // First beat starts the burst, the counter holds beats still to push
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         wr_state <= avl_tg_pkg::WR_IDLE;
         beat_cnt <= '0;
      end
      else if (!wr_full)
      begin
         case (wr_state)
            avl_tg_pkg::WR_IDLE:
               if (wr_pending)
               begin
                  beat_cnt <= wr_req_r.burst - 1'b1;
                  if (wr_req_r.burst > 1)
                     wr_state <= (wr_req_r.op == avl_tg_pkg::CMD_WRITE) ?
                                 avl_tg_pkg::WR_BURST : avl_tg_pkg::WR_INV_BURST;
               end
            avl_tg_pkg::WR_BURST, avl_tg_pkg::WR_INV_BURST:
            begin
               beat_cnt <= beat_cnt - 1'b1;
               if (beat_cnt == 1)
                  wr_state <= avl_tg_pkg::WR_IDLE;
            end
            default:
               wr_state <= avl_tg_pkg::WR_IDLE;
         endcase
      end
   end

   // Address and size of the burst in flight
   always_ff @(posedge clk)
   begin
      if (!wr_full && wr_state == avl_tg_pkg::WR_IDLE && wr_pending)
      begin
         last_addr <= wr_req_r.addr;
         last_size <= wr_req_r.burst;
      end
   end

   // FIFO input and sequencer ready
   always_comb
   begin
      ready_w     = 1'b0;
      wr_push     = 1'b0;
      wr_din.inv  = 1'b0;
      wr_din.addr = last_addr;
      wr_din.size = last_size;
      if (!wr_full)
      begin
         case (wr_state)
            avl_tg_pkg::WR_IDLE:
            begin
               ready_w = 1'b1;
               if (wr_pending)
               begin
                  wr_push     = 1'b1;
                  wr_din.inv  = (wr_req_r.op == avl_tg_pkg::CMD_INV_WRITE);
                  wr_din.addr = wr_req_r.addr;
                  wr_din.size = wr_req_r.burst;
               end
            end
            // No new command while the burst is pushed
            avl_tg_pkg::WR_BURST, avl_tg_pkg::WR_INV_BURST:
            begin
               wr_push    = 1'b1;
               wr_din.inv = (wr_state == avl_tg_pkg::WR_INV_BURST);
            end
            default:
               ready_w = 1'b0;
         endcase
      end
      else
         ready_w = ~wr_pending;
   end

   avl_tg_fifo #(
      .WIDTH   ($bits(wr_entry_t))
   ) wr_fifo (
      .clk     (clk),
      .reset_n (reset_n),
      .push    (wr_push),
      .pop     (wr_pop),
      .din     (wr_din),
      .dout    (wr_dout),
      .full    (wr_full),
      .empty   (wr_empty)
   );

   //////////////////////////////////////////////////////////////////////
   // Avalon write port
   //////////////////////////////////////////////////////////////////////
   assign wr_pop            = can_issue_w & ~wr_empty;
   assign wdata_gen_enable  = wr_pop & ~wr_dout.inv;
   assign inv_be_gen_enable = wr_pop & wr_dout.inv;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         avl_write_req <= 1'b0;
      else if (can_issue_w)
         avl_write_req <= ~wr_empty;
   end

   // Inverted beats write zeros under the complemented enables
   always_ff @(posedge clk)
   begin
      if (wr_pop)
      begin
         avl_wr.addr  <= wr_dout.addr;
         avl_wr.size  <= wr_dout.size;
         avl_wr.wdata <= wr_dout.inv ? '0 : wdata;
         avl_wr.be    <= wr_dout.inv ? inv_be : be;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Read path
   //////////////////////////////////////////////////////////////////////
   assign ready_r     = ~rd_full | ~rd_pending;
   assign rd_push     = ~rd_full & rd_pending;
   assign rd_din.addr = rd_req_r.addr;
   assign rd_din.size = rd_req_r.burst;

   avl_tg_fifo #(
      .WIDTH   ($bits(avl_tg_pkg::avl_rd_cmd_t))
   ) rd_fifo (
      .clk     (clk),
      .reset_n (reset_n),
      .push    (rd_push),
      .pop     (rd_pop),
      .din     (rd_din),
      .dout    (rd_dout),
      .full    (rd_full),
      .empty   (rd_empty)
   );

   assign rd_pop = can_issue_r & ~rd_empty;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
         avl_read_req <= 1'b0;
      else if (can_issue_r)
         avl_read_req <= ~rd_empty;
   end

   always_ff @(posedge clk)
   begin
      if (rd_pop)
         avl_rd <= rd_dout;
   end

   // Read transferred on Avalon
   assign write_done = avl_read_req & avl_ready_r;

endmodule

`default_nettype wire

//--- avl_tg_sequencer.sv
/*
  Loop FSM, each loop sends write, inverted write and read to one region
  A command is held until its ready is seen high at a clock edge
  One run per reset, done stays high until the next reset
*/
`default_nettype none
`timescale 1ns/10ps

`include "avl_tg_macros.svh"

module avl_tg_sequencer (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                start,
   input  logic                ready_w,
   input  logic                ready_r,
   output avl_tg_pkg::tg_req_t wr_cmd,
   output avl_tg_pkg::tg_req_t rd_cmd,
   input  logic                write_done,
   output logic                done
);

   localparam int LOOP_W = $clog2(`AVL_TG_NUM_LOOPS + 1);

   typedef enum logic [2:0]
   {
      SEQ_IDLE,
      SEQ_WRITE,
      SEQ_INV,
      SEQ_READ,
      SEQ_WAIT,
      SEQ_DONE
   } seq_state_e;

   seq_state_e        state;
   logic [LOOP_W-1:0] i;
   logic [LOOP_W-1:0] rd_seen;
   logic              last_loop;

   // Region of loop idx, burst cycles through 1 to 8 beats
   function automatic avl_tg_pkg::tg_req_t make_req(input avl_tg_pkg::tg_cmd_e op,
                                                    input logic [LOOP_W-1:0] idx);
      avl_tg_pkg::tg_req_t req;
      req.op    = op;
      req.addr  = `AVL_TG_ADDR_W'(idx * `AVL_TG_ADDR_STRIDE);
      req.burst = `AVL_TG_BURST_W'(idx % 8) + 1'b1;
      return req;
   endfunction

   assign last_loop = (i == LOOP_W'(`AVL_TG_NUM_LOOPS - 1));

   //////////////////////////////////////////////////////////////////////
   // Loop FSM
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state   <= SEQ_IDLE;
         i       <= '0;
         rd_seen <= '0;
         wr_cmd  <= '0;
         rd_cmd  <= '0;
         done    <= 1'b0;
      end
      else
      begin
         // Reads that left on Avalon
         if (write_done)
            rd_seen <= rd_seen + 1'b1;

         case (state)
            SEQ_IDLE:
               if (start)
               begin
                  i      <= '0;
                  wr_cmd <= make_req(avl_tg_pkg::CMD_WRITE, '0);
                  state  <= SEQ_WRITE;
               end

            // Random write taken, offer the inverted one
            SEQ_WRITE:
               if (ready_w)
               begin
                  wr_cmd <= make_req(avl_tg_pkg::CMD_INV_WRITE, i);
                  state  <= SEQ_INV;
               end

            SEQ_INV:
               if (ready_w)
               begin
                  wr_cmd.op <= avl_tg_pkg::CMD_NONE;
                  rd_cmd    <= make_req(avl_tg_pkg::CMD_READ, i);
                  state     <= SEQ_READ;
               end

            // Read taken, next loop or drain
            SEQ_READ:
               if (ready_r)
               begin
                  rd_cmd.op <= avl_tg_pkg::CMD_NONE;
                  if (last_loop)
                     state <= SEQ_WAIT;
                  else
                  begin
                     i      <= i + 1'b1;
                     wr_cmd <= make_req(avl_tg_pkg::CMD_WRITE, i + 1'b1);
                     state  <= SEQ_WRITE;
                  end
               end

            // All reads must reach Avalon before done
            SEQ_WAIT:
               if (rd_seen == LOOP_W'(`AVL_TG_NUM_LOOPS))
               begin
                  done  <= 1'b1;
                  state <= SEQ_DONE;
               end

            SEQ_DONE:
               state <= SEQ_DONE;

            default:
               state <= SEQ_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- avl_tg_wdata_gen.sv
/*
  Pseudo-random write data and byte enables from three Galois LFSRs
  Byte enable width must be at least 2
  Outputs move only on the edge after their enable
*/
`default_nettype none
`timescale 1ns/10ps

`include "avl_tg_macros.svh"

module avl_tg_wdata_gen (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      wdata_gen_enable,
   input  logic                      inv_be_gen_enable,
   output logic [`AVL_TG_DATA_W-1:0] wdata,
   output logic [`AVL_TG_BE_W-1:0]   be,
   output logic [`AVL_TG_BE_W-1:0]   inv_be
);

   logic [31:0] data_lfsr;
   logic [31:0] be_lfsr;
   logic [31:0] inv_lfsr;

   // One Galois step to the right
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic [31:0] shifted;
      shifted = s >> 1;
      return s[0] ? (shifted ^ `AVL_TG_LFSR_POLY) : shifted;
   endfunction

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         data_lfsr <= `AVL_TG_DATA_SEED;
         be_lfsr   <= `AVL_TG_BE_SEED;
         inv_lfsr  <= `AVL_TG_BE_SEED;
      end
      else
      begin
         // Normal write beats move data and be together
         if (wdata_gen_enable)
         begin
            data_lfsr <= lfsr_next(data_lfsr);
            be_lfsr   <= lfsr_next(be_lfsr);
         end
         // Same seed, so the inverted burst replays the be sequence
         if (inv_be_gen_enable)
            inv_lfsr <= lfsr_next(inv_lfsr);
      end
   end

   assign wdata = data_lfsr[`AVL_TG_DATA_W-1:0];

   // Byte 0 always written, so no beat is empty
   assign be = {be_lfsr[`AVL_TG_BE_W-1:1], 1'b1};

   // Byte 0 never rewritten with zeros
   assign inv_be = {~inv_lfsr[`AVL_TG_BE_W-1:1], 1'b0};

endmodule

`default_nettype wire

//--- avl_tg_fifo.sv
/*
  Show-ahead register FIFO, dout is the oldest entry while not empty
  Push when full and pop when empty are ignored
  Depth is AVL_TG_FIFO_DEPTH for every instance
*/
`default_nettype none
`timescale 1ns/10ps

`include "avl_tg_macros.svh"

module avl_tg_fifo #(
   parameter int WIDTH = 8
) (
   input  logic             clk,
   input  logic             reset_n,
   input  logic             push,
   input  logic             pop,
   input  logic [WIDTH-1:0] din,
   output logic [WIDTH-1:0] dout,
   output logic             full,
   output logic             empty
);

   localparam int DEPTH = `AVL_TG_FIFO_DEPTH;
   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;
   assign full    = (count == CNT_W'(DEPTH));
   assign empty   = (count == '0);

   // Head of queue, no read latency
   assign dout = mem[rd_ptr];

   // Storage
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr] <= din;
   end

   // Pointers wrap at DEPTH, which need not be a power of two
   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- avl_tg_pkg.sv
/*
  Types shared by the sequencer, the translator and the testbench
  Field widths come from the macros header
*/
`default_nettype none

`include "avl_tg_macros.svh"

package avl_tg_pkg;

   // Command from the sequencer
   typedef enum logic [1:0]
   {
      CMD_NONE,
      CMD_WRITE,
      CMD_INV_WRITE,
      CMD_READ
   } tg_cmd_e;

   // Translator write burst state
   typedef enum logic [1:0]
   {
      WR_IDLE,
      WR_BURST,
      WR_INV_BURST
   } wr_state_e;

   // One beat on the Avalon write port
   typedef struct packed
   {
      logic [`AVL_TG_ADDR_W-1:0]  addr;
      logic [`AVL_TG_BURST_W-1:0] size;
      logic [`AVL_TG_DATA_W-1:0]  wdata;
      logic [`AVL_TG_BE_W-1:0]    be;
   } avl_wr_cmd_t;

   // One command on the Avalon read port
   typedef struct packed
   {
      logic [`AVL_TG_ADDR_W-1:0]  addr;
      logic [`AVL_TG_BURST_W-1:0] size;
   } avl_rd_cmd_t;

   // Sequencer request, burst counts beats
   typedef struct packed
   {
      tg_cmd_e                    op;
      logic [`AVL_TG_ADDR_W-1:0]  addr;
      logic [`AVL_TG_BURST_W-1:0] burst;
   } tg_req_t;

endpackage

`default_nettype wire

//--- avl_tg_macros.svh
/*
  Sizes and LFSR constants for the traffic generator
  Data width is at most 32 bits, as it is taken from one 32-bit LFSR
  Seeds must be nonzero or the LFSRs lock up at zero
*/
`ifndef AVL_TG_MACROS_SVH
`define AVL_TG_MACROS_SVH

// Avalon port widths
`define AVL_TG_ADDR_W        16
`define AVL_TG_BURST_W       4
`define AVL_TG_DATA_W        32
`define AVL_TG_BE_W          (`AVL_TG_DATA_W / 8)

// Entries per command FIFO
`define AVL_TG_FIFO_DEPTH    4

// Loop pattern, largest burst is 8 beats
`define AVL_TG_NUM_LOOPS     6
`define AVL_TG_ADDR_STRIDE   16

// Galois LFSR, shift right and xor the mask when bit 0 falls out
`define AVL_TG_DATA_SEED     32'h5EED_1234
`define AVL_TG_BE_SEED       32'h0C3A_96E5
`define AVL_TG_LFSR_POLY     32'h8020_0003

`endif
